//--- hdl/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   take,
    input  cmd_pkg::frame_fields_t fields,
    input  logic                   part_ok,
    input  logic                   pass_ok,
    output cmd_pkg::btype_e        btype,
    output cmd_pkg::com_cfg_t      com_next,
    output cmd_pkg::trig_cfg_t     trig_next,
    output logic                   com_load,
    output logic                   trig_load,
    output logic                   cmd_clear
);

    import cmd_pkg::*;

    logic conf_take;

    ////////////////////////////////////////
    // frame type
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btype <= btype_init;
        end else if (take && part_ok && pass_ok) begin
            case (fields.func)
                func_conf: btype <= btype_conf;
                func_read: btype <= btype_read;
                func_stop: btype <= btype_stop;
                func_rxd0: btype <= btype_rxd0;
                func_rxd1: btype <= btype_rxd1;
                default:   btype <= btype;          // unknown code, keep.
            endcase
        end
    end

    ////////////////////////////////////////
    // command payloads
    ////////////////////////////////////////

    // conf payload loads without the password match.
    assign conf_take = take && part_ok && (fields.func == func_conf);
    assign com_load = conf_take;
    assign trig_load = conf_take;
    assign cmd_clear = take && !part_ok;            // bad frame wipes both.

    assign com_next.rate_sel = fields.rate[3:0];
    assign com_next.lfilt_sel = fields.filt[11:8];  // byte 8.
    assign com_next.hfilt_sel = fields.filt[3:0];   // byte 9.

    assign trig_next.trig_src = fields.trgg[11:8];
    assign trig_next.trig_mode = fields.trgg[3:0];
    assign trig_next.dly0 = fields.dly0;
    assign trig_next.dly1 = fields.dly1;

endmodule

//--- hdl/cmd_hold.sv
`timescale 1ns/1ps

module cmd_hold #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  logic     clear,
    input  payload_t next,
    output payload_t value
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            value <= '0;
        end else if (clear) begin
            value <= '0;                    // clear wins over load.
        end else if (load) begin
            value <= next;
        end
    end

endmodule

//--- hdl/cmd_pkg.sv
package cmd_pkg;

    ////////////////////////////////////////
    // frame layout and timing
    ////////////////////////////////////////

    localparam int frame_len = 18;                  // bytes per command frame.
    localparam int word_cnt = frame_len / 2;        // big-endian 16-bit words.
    localparam int read_latency = 2;                // ram address to data.
    localparam int cap_start = read_latency + 1;    // address register adds one.
    localparam int work_len = frame_len + cap_start;
    localparam int cap_w = 5;

    localparam logic [7:0] ram_base = 8'h0A;        // address of frame byte 0.
    localparam logic [15:0] std_head = 16'h55AA;

    // function codes
    localparam logic [15:0] func_conf = 16'h001E;
    localparam logic [15:0] func_read = 16'h004C;
    localparam logic [15:0] func_stop = 16'h0097;
    localparam logic [15:0] func_rxd0 = 16'h002D;
    localparam logic [15:0] func_rxd1 = 16'h00D2;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        btype_init = 4'd0,
        btype_conf = 4'd1,
        btype_read = 4'd2,
        btype_stop = 4'd3,
        btype_rxd0 = 4'd4,
        btype_rxd1 = 4'd5
    } btype_e;

    typedef struct packed {
        logic [15:0] head;
        logic [15:0] didx;      // device index.
        logic [15:0] func;
        logic [15:0] rate;
        logic [15:0] filt;      // low filter byte on top.
        logic [15:0] trgg;
        logic [15:0] dly0;
        logic [15:0] dly1;
        logic [15:0] part;      // checksum.
    } frame_fields_t;

    typedef struct packed {
        logic [3:0] rate_sel;
        logic [3:0] lfilt_sel;
        logic [3:0] hfilt_sel;
    } com_cfg_t;

    typedef struct packed {
        logic [3:0] trig_src;
        logic [3:0] trig_mode;
        logic [15:0] dly0;
        logic [15:0] dly1;
    } trig_cfg_t;

endpackage

//--- hdl/cmd_rx_top.sv
`timescale 1ns/1ps

module cmd_rx_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en,
    input  logic [7:0]         wr_addr,
    input  logic [7:0]         wr_data,
    input  logic               fs_eth,
    output logic               fd_eth,
    output logic               fs,
    input  logic               fd,
    input  logic [15:0]        password,
    output cmd_pkg::btype_e    btype,
    output cmd_pkg::com_cfg_t  com_cmd,
    output cmd_pkg::trig_cfg_t trgg_cmd
);

    import cmd_pkg::*;

    logic [7:0] rd_addr;
    logic [7:0] rd_data;
    logic cap_en;
    logic [cap_w-1:0] cap_idx;
    logic take;
    frame_fields_t fields;
    logic part_ok;
    logic pass_ok;
    com_cfg_t com_next;
    trig_cfg_t trig_next;
    logic com_load;
    logic trig_load;
    logic cmd_clear;

    rx_frame_ram u_ram (
        .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    frame_reader u_reader (
        .clk(clk), .rst(rst), .fs_eth(fs_eth), .fd_eth(fd_eth),
        .fs(fs), .fd(fd), .rd_addr(rd_addr), .cap_en(cap_en),
        .cap_idx(cap_idx), .take(take)
    );

    field_capture u_capture (
        .clk(clk), .rst(rst), .cap_en(cap_en), .cap_idx(cap_idx),
        .rd_data(rd_data), .password(password), .fields(fields),
        .part_ok(part_ok), .pass_ok(pass_ok)
    );

    cmd_decode u_decode (
        .clk(clk), .rst(rst), .take(take), .fields(fields),
        .part_ok(part_ok), .pass_ok(pass_ok), .btype(btype),
        .com_next(com_next), .trig_next(trig_next), .com_load(com_load),
        .trig_load(trig_load), .cmd_clear(cmd_clear)
    );

    cmd_hold #(.payload_t(com_cfg_t)) com_hold (
        .clk(clk), .rst(rst), .load(com_load), .clear(cmd_clear),
        .next(com_next), .value(com_cmd)
    );

    cmd_hold #(.payload_t(trig_cfg_t)) trig_hold (
        .clk(clk), .rst(rst), .load(trig_load), .clear(cmd_clear),
        .next(trig_next), .value(trgg_cmd)
    );

endmodule

//--- hdl/field_capture.sv
`timescale 1ns/1ps

module field_capture (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cap_en,
    input  logic [cmd_pkg::cap_w-1:0] cap_idx,
    input  logic [7:0]                rd_data,
    input  logic [15:0]               password,
    output cmd_pkg::frame_fields_t    fields,
    output logic                      part_ok,
    output logic                      pass_ok
);

    import cmd_pkg::*;

    logic [0:word_cnt-1][15:0] words;       // word 0 sits in the top bits.
    logic [15:0] sum;

    ////////////////////////////////////////
    // byte assembly
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            words <= '0;
        end else if (cap_en) begin
            if (cap_idx[0]) begin
                words[cap_idx[cap_w-1:1]][7:0] <= rd_data;      // odd byte, low half.
            end else begin
                words[cap_idx[cap_w-1:1]][15:8] <= rd_data;     // even byte, high half.
            end
        end
    end

    assign fields = frame_fields_t'(words);

    ////////////////////////////////////////
    // frame checks
    ////////////////////////////////////////

    // wraps at 16 bits, like the sender's sum.
    always_comb begin
        sum = fields.didx + fields.func + fields.rate + fields.filt
            + fields.trgg + fields.dly0 + fields.dly1;
    end

    assign part_ok = (sum == fields.part) && (fields.head == std_head);
    assign pass_ok = (fields.didx == password);

endmodule

//--- hdl/frame_reader.sv
`timescale 1ns/1ps

module frame_reader (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fs_eth,
    output logic                    fd_eth,
    output logic                    fs,
    input  logic                    fd,
    output logic [7:0]              rd_addr,
    output logic                    cap_en,
    output logic [cmd_pkg::cap_w-1:0] cap_idx,
    output logic                    take
);

    import cmd_pkg::*;

    typedef enum logic [5:0] {
        st_idle = 6'b000001,
        st_wait = 6'b000010,
        st_work = 6'b000100,
        st_take = 6'b001000,
        st_rest = 6'b010000,
        st_done = 6'b100000
    } state_t;

    state_t state;
    state_t state_nxt;
    logic [cap_w-1:0] num;

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: state_nxt = st_wait;
            st_wait: if (fs_eth) state_nxt = st_work;
            st_work: if (num == cap_w'(work_len - 1)) state_nxt = st_take;
            st_take: state_nxt = st_rest;
            st_rest: if (!fs_eth) state_nxt = st_done;      // ethernet side let go.
            st_done: if (fd) state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    ////////////////////////////////////////
    // byte counter and read address
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= '0;
            rd_addr <= ram_base;
        end else begin
            num <= (state == st_work) ? num + 1'b1 : '0;
            if (state == st_work && num < frame_len) begin
                rd_addr <= ram_base + 8'(num);
            end else begin
                rd_addr <= ram_base;                        // parked between frames.
            end
        end
    end

    // data for byte k shows up cap_start cycles after num == k.
    assign cap_en = (state == st_work) && (num >= cap_start);
    assign cap_idx = num - cap_w'(cap_start);

    assign take = (state == st_take);
    assign fd_eth = (state == st_rest);
    assign fs = (state == st_done);

endmodule

//--- hdl/rx_frame_ram.sv
`timescale 1ns/1ps

module rx_frame_ram (
    input  logic       clk,
    input  logic       wr_en,
    input  logic [7:0] wr_addr,
    input  logic [7:0] wr_data,
    input  logic [7:0] rd_addr,
    output logic [7:0] rd_data
);

    logic [7:0] mem [0:255];
    logic [7:0] rd_addr_q;

    ////////////////////////////////////////
    // write port, ethernet side
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // read port, two registered stages
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;               // first stage.
        rd_data <= mem[rd_addr_q];          // second stage.
    end

endmodule

//--- list.f
hdl/cmd_pkg.sv
hdl/rx_frame_ram.sv
hdl/frame_reader.sv
hdl/field_capture.sv
hdl/cmd_decode.sv
hdl/cmd_hold.sv
hdl/cmd_rx_top.sv
testbench/cmd_rx_assert.sv
testbench/tb_cmd_rx.sv

//--- testbench/cmd_rx_assert.sv
`timescale 1ns/1ps

module cmd_rx_assert (
    input logic                      clk,
    input logic                      rst,
    input logic [5:0]                state,
    input logic                      fd_eth,
    input logic                      fs,
    input logic [7:0]                rd_addr,
    input logic                      cap_en,
    input logic [cmd_pkg::cap_w-1:0] cap_idx
);

    import cmd_pkg::*;

    state_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
        else $error("frame reader state is not one-hot");

    no_double_level: assert property (@(posedge clk) disable iff (rst) !(fd_eth && fs))
        else $error("fd_eth and fs are high together");

    // address went out two cycles before, ram adds the rest.
    cap_offset: assert property (@(posedge clk) disable iff (rst)
        cap_en |-> $past(rd_addr, 2) == ram_base + 8'(cap_idx))
        else $error("capture strobe does not match the read address");

endmodule

bind frame_reader cmd_rx_assert u_assert (
    .clk(clk), .rst(rst), .state(state), .fd_eth(fd_eth), .fs(fs),
    .rd_addr(rd_addr), .cap_en(cap_en), .cap_idx(cap_idx)
);

//--- testbench/cmd_rx_golden.txt
// columns: frame bytes 0..17, password, btype, com_cmd, trgg_cmd (all hex)
// one line per test, run in order
55 AA 12 34 00 1E 00 05 03 07 02 01 01 00 00 20 18 7F 1234 1 537 2101000020
55 AA 12 34 00 4C 00 11 00 22 00 33 00 44 00 55 13 7F 1234 2 537 2101000020
55 AA 12 34 00 97 00 00 00 00 00 00 00 00 00 00 12 CB 1234 3 537 2101000020
55 AA 12 34 00 2D 00 00 00 00 00 00 00 00 00 00 12 61 1234 4 537 2101000020
55 AA 12 34 00 D2 00 00 00 00 00 00 00 00 00 00 13 06 1234 5 537 2101000020
55 AA 12 35 00 1E 00 0A 0B 0C 0D 0E AB CD 12 34 E8 78 1234 5 ABC DEABCD1234
55 AA 12 34 00 1E 00 05 03 07 02 01 01 00 00 20 18 7E 1234 5 000 0000000000
55 AA 12 34 00 1E 00 05 03 07 02 01 01 00 00 20 18 7F 1234 1 537 2101000020
55 AB 12 34 00 1E 00 05 03 07 02 01 01 00 00 20 18 7F 1234 1 000 0000000000
55 AA 12 34 00 1E 00 0A 0B 0C 0D 0E AB CD 12 34 E8 77 1234 1 ABC DEABCD1234
55 AA 12 34 00 55 00 00 00 00 00 00 00 00 00 00 12 89 1234 1 ABC DEABCD1234
55 AA 12 34 00 4C 00 11 00 22 00 33 00 44 00 55 13 7F 1234 2 ABC DEABCD1234

//--- testbench/tb_cmd_rx.sv
`timescale 1ns/1ps

module tb_cmd_rx;

    import cmd_pkg::*;

    localparam int n_tests = 12;
    localparam int line_w = frame_len + 4;          // bytes, password, btype, com, trgg.
    localparam int cycle_limit = n_tests * 60 + 100;

    logic clk;
    logic rst;
    logic wr_en;
    logic [7:0] wr_addr;
    logic [7:0] wr_data;
    logic fs_eth;
    logic fd_eth;
    logic fs;
    logic fd;
    logic [15:0] password;
    btype_e btype;
    com_cfg_t com_cmd;
    trig_cfg_t trgg_cmd;

    logic [39:0] gold [0:n_tests*line_w-1];
    int cycles;
    int fs_rises;
    int errors;
    int passed;
    logic fs_q;
    logic test_ok;

    cmd_rx_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // cycle limit and fs edge count
    ////////////////////////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        fs_q <= fs;
        if (fs && !fs_q) begin
            fs_rises <= fs_rises + 1;
        end
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check(input string name, input logic [39:0] got, input logic [39:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic load_frame(input int base);
        for (int i = 0; i < frame_len; i++) begin
            @(posedge clk);
            #2;
            wr_en = 1'b1;
            wr_addr = ram_base + 8'(i);
            wr_data = gold[base + i][7:0];
        end
        @(posedge clk);
        #2;
        wr_en = 1'b0;
    endtask

    // fs_eth falls a few cycles after fd_eth, then wait for the command.
    task automatic send_frame();
        int hold;
        hold = $urandom % 6;
        fs_eth = 1'b1;
        do @(negedge clk); while (!fd_eth);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check("fd_eth", 40'(fd_eth), 40'h1);    // held until fs_eth drops.
            check("fs", 40'(fs), 40'h0);
        end
        @(posedge clk);
        #2;
        fs_eth = 1'b0;
        do @(negedge clk); while (!fs);
        check("fd_eth", 40'(fd_eth), 40'h0);
    endtask

    task automatic release_command();
        int delay;
        delay = $urandom % 4;
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            check("fs", 40'(fs), 40'h1);            // held until fd.
        end
        @(posedge clk);
        #2;
        fd = 1'b1;
        @(posedge clk);
        #2;
        fd = 1'b0;                                  // one cycle is enough in DONE.
        @(negedge clk);
        check("fs", 40'(fs), 40'h0);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int base;
        void'($urandom(32'hdb2e));
        rst = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        fs_eth = 1'b0;
        fd = 1'b0;
        password = '0;
        cycles = 0;
        fs_rises = 0;
        fs_q = 1'b0;
        errors = 0;
        passed = 0;
        $readmemh("testbench/cmd_rx_golden.txt", gold);
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int t = 0; t < n_tests; t++) begin
            base = t * line_w;
            test_ok = 1'b1;
            password = gold[base + frame_len][15:0];
            load_frame(base);
            send_frame();
            check("btype", 40'(btype), gold[base + frame_len + 1]);
            check("com_cmd", 40'(com_cmd), gold[base + frame_len + 2]);
            check("trgg_cmd", 40'(trgg_cmd), gold[base + frame_len + 3]);
            release_command();
            check("fs_count", 40'(fs_rises), 40'(t + 1));  // one fs per frame.
            if (test_ok) begin
                passed++;
                $display("test %0d ok", t);
            end else begin
                $display("test %0d failed", t);
            end
        end
        $display("%0d tests run, %0d passed, %0d failed", n_tests, passed, n_tests - passed);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
